// ==== hw/io_cfg.svh ====
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

`define IO_DW      16 // io data word
`define IO_SLOTS   4  // thread slots, slot 0 is the main thread
`define SAMPLE_AW  8  // 256 sample words

// one-hot select bit positions in the io address
`define SEL_PMOD   0
`define SEL_DIR    1
`define SEL_LED    2
`define SEL_TASK1  8
`define SEL_TASK2  9
`define SEL_TASK3  10
`define SEL_SAMPLE 11
`define SEL_MISC   13  // misc flags on write, status on read
`define SEL_FETCH  14
`define SEL_MASK   15  // mask preset on write, ticks on read

`endif

// ==== hw/io_bus_pkg.sv ====
`include "io_cfg.svh"

// types seen on the bus side of the io subsystem
package io_bus_pkg;

  // one data word, same width for reads and writes
  typedef logic [`IO_DW-1:0] io_word_t;

  // one-hot device select
  // several set bits hit several devices in the same access
  typedef logic [15:0] io_sel_t;

  // thread slot that issued the access
  typedef logic [$clog2(`IO_SLOTS)-1:0] slot_t;

endpackage

// ==== hw/io_dev_pkg.sv ====
`include "io_cfg.svh"

// types used inside the io devices
package io_dev_pkg;

  // misc register layout, msb first
  typedef struct packed {
    logic                  boot;        // warm boot request, no target here
    logic                  flash_sck;
    logic                  flash_mosi;
    logic                  flash_cs;
    logic                  set_wptr;    // preset sample write pointer
    logic                  set_rptr;    // preset sample read pointer
    logic                  exc_off;     // old excitation control, ignored
    logic                  exc_on;      // ignored as well
    logic [`SAMPLE_AW-1:0] sample_addr; // value for the pointer preset
  } misc_flags_t;

  // the write word is plain data for most devices and a flag set for misc
  typedef union packed {
    io_bus_pkg::io_word_t raw;
    misc_flags_t          flags;
  } misc_word_u;

  // task xt for one slot, valid xts are even
  typedef logic [`IO_DW-1:0] task_entry_t;

  localparam int TASK_ONCE = 0; // lsb set means run once, then clear

endpackage

// ==== hw/io_ctrl.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_ctrl (
  input  logic                       clk,
  input  logic                       resetq,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  io_bus_pkg::io_sel_t        wb_adr,
  input  io_bus_pkg::io_word_t       wb_dat_w,
  input  io_bus_pkg::slot_t          slot,
  output logic                       wb_ack,
  output io_bus_pkg::io_word_t       wb_dat_r,
  output logic                       acc,
  output logic                       acc_we,
  output io_bus_pkg::io_sel_t        acc_sel,
  output io_bus_pkg::io_word_t       acc_dat,
  output io_bus_pkg::slot_t          acc_slot,
  input  io_bus_pkg::io_word_t       mask,
  input  io_bus_pkg::io_word_t       pmod_rd,
  input  io_bus_pkg::io_word_t       dir_rd,
  input  io_bus_pkg::io_word_t       led_rd,
  input  io_bus_pkg::io_word_t [3:1] task_rd,
  input  io_bus_pkg::io_word_t       fetch_rd,
  input  io_bus_pkg::io_word_t       sample_rd,
  input  logic [2:0]                 flash_rd,  // {sck, mosi, cs}
  input  logic                       flash_miso
);
  import io_bus_pkg::*;

  logic     req;    // first cycle of a new access
  io_word_t ticks;  // wall clock, wraps
  io_word_t status;
  io_word_t rd_any; // or of all selected device words

  assign req = wb_cyc & wb_stb & ~wb_ack; // low during ack, so ack is one cycle

  always_ff @(posedge clk) begin
    if (!resetq) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // request held for the ack cycle, devices act at its closing edge
  always_ff @(posedge clk) begin
    if (req) begin
      acc_we   <= wb_we;
      acc_sel  <= wb_adr;
      acc_dat  <= wb_dat_w;
      acc_slot <= slot;
    end
  end

  assign acc = wb_ack; // one strobe per access

  always_ff @(posedge clk) begin
    if (!resetq) begin
      ticks <= '0;
    end else begin
      ticks <= ticks + 1'b1;
    end
  end

  // msb tells the slot apart from slot 0
  assign status = {(|acc_slot), 9'd0, flash_rd, flash_miso, 2'd0};

  assign rd_any = (acc_sel[`SEL_PMOD]   ? pmod_rd    : '0) |
                  (acc_sel[`SEL_DIR]    ? dir_rd     : '0) |
                  (acc_sel[`SEL_LED]    ? led_rd     : '0) |
                  (acc_sel[`SEL_TASK1]  ? task_rd[1] : '0) |
                  (acc_sel[`SEL_TASK2]  ? task_rd[2] : '0) |
                  (acc_sel[`SEL_TASK3]  ? task_rd[3] : '0) |
                  (acc_sel[`SEL_SAMPLE] ? sample_rd  : '0) |
                  (acc_sel[`SEL_MISC]   ? status     : '0) |
                  (acc_sel[`SEL_FETCH]  ? fetch_rd   : '0) |
                  (acc_sel[`SEL_MASK]   ? ticks      : '0);  // ticks share the mask bit

  assign wb_dat_r = rd_any & mask; // cleared mask bits read as zero

endmodule

// ==== hw/io_mask_preset.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_mask_preset (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 acc,
  input  logic                 acc_we,
  input  io_bus_pkg::io_sel_t  acc_sel,
  input  io_bus_pkg::io_word_t acc_dat,
  input  io_bus_pkg::slot_t    acc_slot,
  output io_bus_pkg::io_word_t mask
);
  import io_bus_pkg::*;

  io_word_t masks [`IO_SLOTS]; // one preset per thread slot

  // each access by a slot consumes its mask
  // a mask write arms it again for the very next access of that slot
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < `IO_SLOTS; i++)
        masks[i] <= '1;
    end else if (acc) begin
      masks[acc_slot] <= (acc_we & acc_sel[`SEL_MASK]) ? acc_dat : '1;
    end
  end

  assign mask = masks[acc_slot]; // other slots never see it

endmodule

// ==== hw/task_sched.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module task_sched (
  input  logic                       clk,
  input  logic                       resetq,
  input  logic                       acc,
  input  logic                       acc_we,
  input  io_bus_pkg::io_sel_t        acc_sel,
  input  io_bus_pkg::io_word_t       acc_dat,
  input  io_bus_pkg::slot_t          acc_slot,
  output io_bus_pkg::io_word_t [3:1] task_rd,
  output io_bus_pkg::io_word_t       fetch_rd,
  output logic [`IO_SLOTS-1:0]       kill_slot_rq
);
  import io_bus_pkg::*;
  import io_dev_pkg::*;

  task_entry_t tasks [1:3]; // slot 0 has no entry
  logic [3:1]  task_wr;     // per-slot task write strobes
  logic        fetch_take;  // fetch read by a non-zero slot
  logic        kill_wr;

  assign task_wr    = {acc_sel[`SEL_TASK3], acc_sel[`SEL_TASK2], acc_sel[`SEL_TASK1]}
                      & {3{acc & acc_we}};
  assign fetch_take = acc & ~acc_we & acc_sel[`SEL_FETCH] & (acc_slot != '0);
  assign kill_wr    = acc & acc_we & acc_sel[`SEL_FETCH];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 1; i <= 3; i++)
        tasks[i] <= '0;  // no slot restarts its old task after reset
      kill_slot_rq <= '0;
    end else begin
      kill_slot_rq <= kill_wr ? acc_dat[`IO_SLOTS-1:0] : '0; // one cycle pulse
      for (int i = 1; i <= 3; i++) begin
        if (task_wr[i])
          tasks[i] <= acc_dat;  // any slot may assign any other
        else if (fetch_take && acc_slot == slot_t'(i) && tasks[i][TASK_ONCE])
          tasks[i] <= '0;       // run-once task gone after first fetch
      end
    end
  end

  always_comb begin
    for (int i = 1; i <= 3; i++)
      task_rd[i] = tasks[i];  // raw word, flag included
  end

  always_comb begin
    fetch_rd = '0;  // slot 0 spins on zero
    for (int i = 1; i <= 3; i++) begin
      if (acc_slot == slot_t'(i))
        fetch_rd = tasks[i];
    end
    fetch_rd[TASK_ONCE] = 1'b0; // hand out an even xt
  end

endmodule

// ==== hw/sample_ram.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module sample_ram (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 acc,
  input  logic                 acc_we,
  input  io_bus_pkg::io_sel_t  acc_sel,
  input  io_bus_pkg::io_word_t acc_dat,
  output io_bus_pkg::io_word_t sample_rd
);
  import io_bus_pkg::*;
  import io_dev_pkg::*;

  io_word_t              mem [2**`SAMPLE_AW];
  logic [`SAMPLE_AW-1:0] wptr;    // next slot to write
  logic [`SAMPLE_AW-1:0] rptr;    // next slot to read
  misc_word_u            misc;    // write word seen as misc flags
  logic                  misc_wr;
  logic                  s_wr;
  logic                  s_rd;

  assign misc    = acc_dat;
  assign misc_wr = acc & acc_we & acc_sel[`SEL_MISC];
  assign s_wr    = acc & acc_we & acc_sel[`SEL_SAMPLE];
  assign s_rd    = acc & ~acc_we & acc_sel[`SEL_SAMPLE];

  always_ff @(posedge clk) begin
    if (s_wr)
      mem[wptr] <= acc_dat;
  end

  // preset wins over the increment when both hit at once
  always_ff @(posedge clk) begin
    if (!resetq) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (misc_wr && misc.flags.set_wptr)
        wptr <= misc.flags.sample_addr;
      else if (s_wr)
        wptr <= wptr + 1'b1;  // wraps at 256
      if (misc_wr && misc.flags.set_rptr)
        rptr <= misc.flags.sample_addr;
      else if (s_rd)
        rptr <= rptr + 1'b1;
    end
  end

  assign sample_rd = mem[rptr]; // word under the read pointer, valid in ack

endmodule

// ==== hw/port_regs.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module port_regs (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 acc,
  input  logic                 acc_we,
  input  io_bus_pkg::io_sel_t  acc_sel,
  input  io_bus_pkg::io_word_t acc_dat,
  input  io_bus_pkg::io_word_t mask,
  input  io_bus_pkg::io_word_t pmod_in,
  output io_bus_pkg::io_word_t pmod_out,
  output io_bus_pkg::io_word_t pmod_oe,   // 1 drives the pin
  output io_bus_pkg::io_word_t pmod_rd,
  output io_bus_pkg::io_word_t dir_rd,
  output logic [7:0]           leds,
  output io_bus_pkg::io_word_t led_rd,
  output logic                 flash_sck,
  output logic                 flash_mosi,
  output logic                 flash_cs,
  output logic [2:0]           flash_rd
);
  import io_bus_pkg::*;
  import io_dev_pkg::*;

  logic       wr;
  misc_word_u misc; // misc view of the write word

  // only bits set in m take the new value
  function automatic io_word_t merge(input io_word_t old, input io_word_t nw,
                                     input io_word_t m);
    return (old & ~m) | (nw & m);
  endfunction

  assign wr   = acc & acc_we;
  assign misc = acc_dat;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      pmod_out   <= '0;
      pmod_oe    <= '0;  // all pins start as inputs
      leds       <= '0;
      flash_sck  <= 1'b0;
      flash_mosi <= 1'b0;
      flash_cs   <= 1'b0;
    end else if (wr) begin
      if (acc_sel[`SEL_PMOD])
        pmod_out <= merge(pmod_out, acc_dat, mask);
      if (acc_sel[`SEL_DIR])
        pmod_oe <= merge(pmod_oe, acc_dat, mask);  // threads share the port bitwise
      if (acc_sel[`SEL_LED])
        leds <= 8'(merge({8'd0, leds}, acc_dat, mask));
      if (acc_sel[`SEL_MISC]) begin
        flash_sck  <= misc.flags.flash_sck;  // flash pins ignore the mask
        flash_mosi <= misc.flags.flash_mosi;
        flash_cs   <= misc.flags.flash_cs;
      end
    end
  end

  assign pmod_rd  = (pmod_in & ~pmod_oe) | (pmod_out & pmod_oe); // pin level as driven
  assign dir_rd   = pmod_oe;
  assign led_rd   = {8'd0, leds};
  assign flash_rd = {flash_sck, flash_mosi, flash_cs};

endmodule

// ==== hw/io_top.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_top (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  io_bus_pkg::io_sel_t  wb_adr,
  input  io_bus_pkg::io_word_t wb_dat_w,
  output logic                 wb_ack,
  output io_bus_pkg::io_word_t wb_dat_r,
  input  io_bus_pkg::slot_t    slot,
  input  io_bus_pkg::io_word_t pmod_in,
  output io_bus_pkg::io_word_t pmod_out,
  output io_bus_pkg::io_word_t pmod_oe,
  output logic [7:0]           leds,
  output logic                 flash_sck,
  output logic                 flash_mosi,
  output logic                 flash_cs,
  input  logic                 flash_miso,
  output logic [`IO_SLOTS-1:0] kill_slot_rq
);
  import io_bus_pkg::*;

  // registered request fanned out to every device
  logic           acc;
  logic           acc_we;
  io_sel_t        acc_sel;
  io_word_t       acc_dat;
  slot_t          acc_slot;
  io_word_t       mask;      // preset of the accessing slot
  // device read words back to the mux
  io_word_t       pmod_rd;
  io_word_t       dir_rd;
  io_word_t       led_rd;
  io_word_t [3:1] task_rd;
  io_word_t       fetch_rd;
  io_word_t       sample_rd;
  logic [2:0]     flash_rd;

  io_ctrl u_ctrl (
    .clk, .resetq, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .slot,
    .wb_ack, .wb_dat_r, .acc, .acc_we, .acc_sel, .acc_dat, .acc_slot,
    .mask, .pmod_rd, .dir_rd, .led_rd, .task_rd, .fetch_rd, .sample_rd,
    .flash_rd, .flash_miso
  );

  io_mask_preset u_mask (
    .clk, .resetq, .acc, .acc_we, .acc_sel, .acc_dat, .acc_slot, .mask
  );

  port_regs u_ports (
    .clk, .resetq, .acc, .acc_we, .acc_sel, .acc_dat, .mask, .pmod_in,
    .pmod_out, .pmod_oe, .pmod_rd, .dir_rd, .leds, .led_rd,
    .flash_sck, .flash_mosi, .flash_cs, .flash_rd
  );

  task_sched u_tasks (
    .clk, .resetq, .acc, .acc_we, .acc_sel, .acc_dat, .acc_slot,
    .task_rd, .fetch_rd, .kill_slot_rq
  );

  sample_ram u_samples (
    .clk, .resetq, .acc, .acc_we, .acc_sel, .acc_dat, .sample_rd
  );

endmodule

// ==== test/io_top_sva.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_top_sva #(
  parameter bit CHK_BUS  = 1'b1, // handshake group
  parameter bit CHK_KILL = 1'b1  // kill pulse group
) (
  input logic                 clk,
  input logic                 resetq,
  input logic                 cyc,
  input logic                 stb,
  input logic                 ack,
  input logic [`IO_SLOTS-1:0] pulse
);

  if (CHK_BUS) begin : g_bus
    // ack answers a request seen one edge earlier
    ack_has_req: assert property (@(posedge clk) disable iff (!resetq)
      ack |-> $past(cyc & stb))
      else $error("ack without cyc and stb on the cycle before");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetq) ack |=> !ack)
      else $error("ack held for two cycles");

    ack_reset_low: assert property (@(posedge clk) !resetq |=> !ack) // sync reset clears ack
      else $error("ack high after reset");
  end

  if (CHK_KILL) begin : g_kill
    kill_one_cycle: assert property (@(posedge clk) disable iff (!resetq)
      (|pulse) |=> (pulse == '0))
      else $error("kill request longer than one cycle");
  end

endmodule

bind io_ctrl io_top_sva #(.CHK_KILL(1'b0)) u_bus_sva (
  .clk, .resetq, .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack), .pulse('0)
);

bind task_sched io_top_sva #(.CHK_BUS(1'b0)) u_kill_sva (
  .clk, .resetq, .cyc(1'b0), .stb(1'b0), .ack(1'b0), .pulse(kill_slot_rq)
);

// ==== test/io_top_tb.sv ====
`timescale 1ns/1ps
`include "io_cfg.svh"

module io_top_tb;
  import io_bus_pkg::*;

  localparam int CLK_NS    = 4;
  localparam int RESET_CYC = 16;
  localparam int ACK_LIMIT = 8;     // cycles from stb to ack before giving up
  localparam int SEED      = 71337;

  // what an entry checks after its access
  localparam logic [2:0] K_NONE  = 3'd0;
  localparam logic [2:0] K_RD    = 3'd1; // read word while ack is high
  localparam logic [2:0] K_LED   = 3'd2;
  localparam logic [2:0] K_OE    = 3'd3;
  localparam logic [2:0] K_OUT   = 3'd4;
  localparam logic [2:0] K_FLASH = 3'd5; // {sck, mosi, cs}
  localparam logic [2:0] K_KILL  = 3'd6; // kill_slot_rq pulse in the low nibble

  typedef struct packed {
    slot_t      slot;
    logic       we;
    io_sel_t    sel;
    io_word_t   data;
    logic [2:0] kind;
    io_word_t   exp;
  } entry_t;

  logic                 clk;
  logic                 resetq;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  io_sel_t              wb_adr;
  io_word_t             wb_dat_w;
  logic                 wb_ack;
  io_word_t             wb_dat_r;
  slot_t                slot;
  io_word_t             pmod_in;
  io_word_t             pmod_out;
  io_word_t             pmod_oe;
  logic [7:0]           leds;
  logic                 flash_sck;
  logic                 flash_mosi;
  logic                 flash_cs;
  logic                 flash_miso;
  logic [`IO_SLOTS-1:0] kill_slot_rq;

  entry_t tbl [$];
  logic   tbl_ready;

  io_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_bits(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_kill(input logic [`IO_SLOTS-1:0] got, input logic [`IO_SLOTS-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail kill_slot_rq got %h exp %h", got, exp));
  endtask

  task automatic push_entry(input slot_t s, input logic we, input int selb, input io_word_t d,
                            input logic [2:0] kind, input io_word_t exp);
    tbl.push_back('{s, we, io_sel_t'(1) << selb, d, kind, exp});
  endtask

  // one wishbone classic access, read word captured in the ack cycle
  task automatic bus_access(input entry_t e, output io_word_t rd);
    int n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= e.we;
    wb_adr   <= e.sel;
    wb_dat_w <= e.data;
    slot     <= e.slot;
    n = 0;
    @(negedge clk);
    while (!wb_ack) begin
      n++;
      if (n > ACK_LIMIT)
        abort_run($sformatf("no ack from the DUT within %0d cycles", ACK_LIMIT));
      @(negedge clk);
    end
    rd = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;  // drop for a cycle before the next access
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);  // device state and pins settled here
  endtask

  task automatic build_table();
    io_word_t rnd [4];
    foreach (rnd[i])
      rnd[i] = io_word_t'($urandom);
    // ports and leds, pmod_in is A5C3
    push_entry(0, 0, `SEL_DIR,  16'h0000, K_RD,  16'h0000);
    push_entry(0, 1, `SEL_DIR,  16'h00ff, K_OE,  16'h00ff);
    push_entry(0, 1, `SEL_PMOD, 16'h1234, K_OUT, 16'h1234);
    push_entry(0, 0, `SEL_PMOD, 16'h0000, K_RD,  16'ha534); // low byte driven, high from pins
    push_entry(0, 0, `SEL_DIR,  16'h0000, K_RD,  16'h00ff);
    push_entry(0, 1, `SEL_LED,  16'h005a, K_LED, 16'h005a);
    push_entry(0, 0, `SEL_LED,  16'h0000, K_RD,  16'h005a);
    // mask presets
    push_entry(1, 1, `SEL_MASK, 16'h000f, K_NONE, 16'h0000);
    push_entry(1, 1, `SEL_LED,  16'h00f3, K_LED, 16'h0053); // only low nibble taken
    push_entry(1, 0, `SEL_LED,  16'h0000, K_RD,  16'h0053);
    push_entry(2, 1, `SEL_MASK, 16'h0003, K_NONE, 16'h0000);
    push_entry(1, 0, `SEL_LED,  16'h0000, K_RD,  16'h0053); // slot 2 mask not seen here
    push_entry(2, 0, `SEL_LED,  16'h0000, K_RD,  16'h0003);
    push_entry(2, 0, `SEL_LED,  16'h0000, K_RD,  16'h0053);
    // tasks
    push_entry(0, 1, `SEL_TASK2, 16'h0101, K_NONE, 16'h0000); // run once
    push_entry(2, 0, `SEL_FETCH, 16'h0000, K_RD, 16'h0100);
    push_entry(2, 0, `SEL_FETCH, 16'h0000, K_RD, 16'h0000);
    push_entry(0, 1, `SEL_TASK3, 16'h0244, K_NONE, 16'h0000);
    push_entry(3, 0, `SEL_FETCH, 16'h0000, K_RD, 16'h0244);
    push_entry(3, 0, `SEL_FETCH, 16'h0000, K_RD, 16'h0244); // kept, no once flag
    push_entry(0, 1, `SEL_TASK1, 16'h0302, K_NONE, 16'h0000);
    push_entry(0, 0, `SEL_FETCH, 16'h0000, K_RD, 16'h0000); // slot 0 gets nothing
    push_entry(1, 0, `SEL_TASK1, 16'h0000, K_RD, 16'h0302);
    push_entry(0, 1, `SEL_FETCH, 16'h00a6, K_KILL, 16'h0006); // kill nibble 6
    // sample ram, a stray word moves wptr off 0, then both pointers to 0x40
    push_entry(0, 1, `SEL_SAMPLE, ~rnd[0], K_NONE, 16'h0000);
    push_entry(0, 1, `SEL_MISC, 16'h0c40, K_FLASH, 16'h0000);
    foreach (rnd[i])
      push_entry(0, 1, `SEL_SAMPLE, rnd[i], K_NONE, 16'h0000);
    foreach (rnd[i])
      push_entry(0, 0, `SEL_SAMPLE, 16'h0000, K_RD, rnd[i]);
    // status, sck and cs high, miso tied high
    push_entry(0, 1, `SEL_MISC, 16'h5000, K_FLASH, 16'h0005);
    push_entry(0, 0, `SEL_MISC, 16'h0000, K_RD, 16'h002c);
    push_entry(3, 0, `SEL_MISC, 16'h0000, K_RD, 16'h802c); // top bit for nonzero slot
  endtask

  initial begin
    int unsigned wd_cycles;
    wait (tbl_ready);
    wd_cycles = (tbl.size() + 2) * 8 + RESET_CYC + 2; // two extra tick reads
    #(wd_cycles * CLK_NS);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    io_word_t                 rd;
    io_word_t                 t0;
    io_word_t                 t1;
    logic [`IO_SLOTS-1:0]     kill_exp;
    entry_t                   tick_rd;
    void'($urandom(SEED));
    tbl_ready  = 1'b0;
    resetq     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    slot       = '0;
    pmod_in    = 16'ha5c3;
    flash_miso = 1'b1;
    build_table();
    tbl_ready = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    resetq <= 1'b1;
    @(negedge clk);
    check_bits("wb_ack", {15'd0, wb_ack}, 16'h0000);
    check_bits("leds", {8'd0, leds}, 16'h0000);
    check_bits("pmod_oe", pmod_oe, 16'h0000);
    check_bits("pmod_out", pmod_out, 16'h0000);
    check_bits("flash", {13'd0, flash_sck, flash_mosi, flash_cs}, 16'h0000);
    check_kill(kill_slot_rq, '0);
    foreach (tbl[i]) begin
      bus_access(tbl[i], rd);
      if (tbl[i].kind == K_RD)
        check_word("wb_dat_r", rd, tbl[i].exp);
      case (tbl[i].kind)
        K_LED:   check_bits("leds", {8'd0, leds}, tbl[i].exp);
        K_OE:    check_bits("pmod_oe", pmod_oe, tbl[i].exp);
        K_OUT:   check_bits("pmod_out", pmod_out, tbl[i].exp);
        K_FLASH: check_bits("flash", {13'd0, flash_sck, flash_mosi, flash_cs}, tbl[i].exp);
        default: ;
      endcase
      // quiet unless the entry expects a pulse
      kill_exp = (tbl[i].kind == K_KILL) ? tbl[i].exp[`IO_SLOTS-1:0] : '0;
      check_kill(kill_slot_rq, kill_exp);
    end
    tick_rd = '{2'd0, 1'b0, io_sel_t'(1) << `SEL_MASK, 16'h0000, K_RD, 16'h0000};
    bus_access(tick_rd, t0);
    bus_access(tick_rd, t1);
    if (t1 <= t0)
      abort_run($sformatf("tick counter did not increase, first %h then %h", t0, t1));
    $display("sim passed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/io_bus_pkg.sv
hw/io_dev_pkg.sv
hw/io_ctrl.sv
hw/io_mask_preset.sv
hw/task_sched.sv
hw/sample_ram.sv
hw/port_regs.sv
hw/io_top.sv
test/io_top_sva.sv
test/io_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the io subsystem testbench with verilator, from the project root

BUILD_LOG=build.log
RUN_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module io_top_tb -o io_top_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/io_top_tb > "$RUN_LOG" 2>&1
run_status=$?
cat "$RUN_LOG"

if grep -q "sim failed" "$RUN_LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
